// File: quickq.f
hdl/quickq_pkg.sv
hdl/pq_if.sv
hdl/quickq.sv
hdl/button_pulser.sv
hdl/sevenseg_ctl.sv
hdl/quickq_hw.sv
verif/quickq_hw_tb.sv

// File: Bender.yml
package:
  name: quickq

sources:
  - hdl/quickq_pkg.sv
  - hdl/pq_if.sv
  - hdl/quickq.sv
  - hdl/button_pulser.sv
  - hdl/sevenseg_ctl.sv
  - hdl/quickq_hw.sv
  - target: simulation
    files:
      - verif/quickq_hw_tb.sv

// File: verif/quickq_hw_tb.sv
`timescale 1ns/1ps

module quickq_hw_tb import quickq_pkg::*; ();

    localparam int DB_CYCLES   = 4;
    localparam int SCAN_CYCLES = 2;
    localparam int FRAME       = 8 * SCAN_CYCLES;
    // Button held and released this long
    localparam int HOLD        = DB_CYCLES + 6;
    localparam int TMO         = 200;
    // Right-shift Galois form of x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clk;
    logic rst;
    logic [15:0] kvi_logic;
    logic enq;
    logic deq;
    logic repl;
    logic full;
    logic busy;
    logic empty;
    logic [6:0] segs_n;
    logic dp_n;
    logic [7:0] an_n;

    // Expected queue contents with the head first
    kv_t model_q [$];
    int errors;
    int timeouts;
    int busy_cnt;
    logic [31:0] lfsr;
    // Frame decode state
    logic chk_req;
    int frame_cnt;
    int digits [8];
    logic [7:0] seen;
    kv_t disp_head;

    quickq_hw #(.DB_CYCLES(DB_CYCLES), .SCAN_CYCLES(SCAN_CYCLES)) uut (
        .clk, .rst, .kvi_logic, .enq, .deq, .repl,
        .full, .busy, .empty, .segs_n, .dp_n, .an_n
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////////////////////

    // Sorted insert behind all entries with an equal or smaller key
    function automatic void model_apply(input pq_op_e op, input kv_t kv);
        int pos;
        logic ins;
        pos = 0;
        ins = (op == OP_REPL) || (op == OP_ENQ && model_q.size() < PQ_DEPTH);
        if ((op == OP_DEQ || op == OP_REPL) && model_q.size() > 0) begin
            void'(model_q.pop_front());
        end
        if (ins) begin
            while (pos < model_q.size() && model_q[pos].key <= kv.key) begin
                pos++;
            end
            model_q.insert(pos, kv);
        end
    endfunction

    function automatic kv_t model_head();
        if (model_q.size() == 0) begin
            return '0;
        end
        return model_q[0];
    endfunction

    // Active-low segments g..a
    function automatic logic [6:0] hex_segments(input int d);
        case (d)
            0: return 7'b1000000;
            1: return 7'b1111001;
            2: return 7'b0100100;
            3: return 7'b0110000;
            4: return 7'b0011001;
            5: return 7'b0010010;
            6: return 7'b0000010;
            7: return 7'b1111000;
            8: return 7'b0000000;
            9: return 7'b0010000;
            10: return 7'b0001000;
            11: return 7'b0000011;
            12: return 7'b1000110;
            13: return 7'b0100001;
            14: return 7'b0000110;
            15: return 7'b0001110;
            default: return 7'b1111111;
        endcase
    endfunction

    // 16 means blank, -1 an unknown pattern
    function automatic int seg_to_digit(input logic [6:0] s);
        for (int d = 0; d < 16; d++) begin
            if (s === hex_segments(d)) begin
                return d;
            end
        end
        return (s === 7'b1111111) ? 16 : -1;
    endfunction

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return b;
    endfunction

    function automatic logic [15:0] rand_word();
        logic [15:0] w;
        for (int i = 0; i < 16; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////////////////////

    // One busy cycle per accepted command
    always @(negedge clk) begin
        if (!rst && busy === 1'b1) begin
            busy_cnt++;
        end
    end

    // Reads one full scan back into digits and compares with the model head
    always @(negedge clk) begin : frame_check
        int idx;
        logic [15:0] exp_word;
        int exp_d;
        if (chk_req) begin
            idx = -1;
            for (int i = 0; i < 8; i++) begin
                if (an_n === ~(8'b1 << i)) begin
                    idx = i;
                end
            end
            assert (idx >= 0) else begin
                errors++;
                $display("FAILED %0t: an_n %b is not one-hot low", $time, an_n);
            end
            if (idx >= 0) begin
                digits[idx] = seg_to_digit(segs_n);
                seen[idx] = 1'b1;
            end
            frame_cnt++;
            if (frame_cnt == FRAME) begin
                exp_word = model_head();
                for (int i = 0; i < 8; i++) begin
                    exp_d = (i < 4) ? int'(exp_word[4*i +: 4]) : 16;
                    assert (seen[i] && digits[i] == exp_d) else begin
                        errors++;
                        $display("FAILED %0t: digit %0d shows %0d, expected %0d",
                                 $time, i, digits[i], exp_d);
                    end
                end
                disp_head = {digits[3][3:0], digits[2][3:0], digits[1][3:0], digits[0][3:0]};
                frame_cnt = 0;
                seen = '0;
                chk_req = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic set_button(input pq_op_e op, input logic val);
        case (op)
            OP_ENQ: enq = val;
            OP_DEQ: deq = val;
            OP_REPL: repl = val;
            default: ;
        endcase
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (busy !== 1'b0 && t < TMO) begin
            step();
            t++;
        end
        if (busy !== 1'b0) begin
            timeouts++;
            $display("Timed out waiting for busy to go low at %0t", $time);
        end
    endtask

    // Press for hold cycles, release, then count the commands the core took
    task automatic press(input pq_op_e op, input logic [15:0] word, input int hold,
                         input int exp_ops);
        int b0;
        b0 = busy_cnt;
        kvi_logic = word;
        set_button(op, 1'b1);
        for (int i = 0; i < hold; i++) begin
            step();
        end
        set_button(op, 1'b0);
        for (int i = 0; i < HOLD; i++) begin
            step();
        end
        wait_idle();
        assert (busy_cnt - b0 == exp_ops) else begin
            errors++;
            $display("FAILED %0t: %0d commands seen, expected %0d", $time, busy_cnt - b0,
                     exp_ops);
        end
    endtask

    task automatic check_all();
        int t;
        assert (empty === (model_q.size() == 0)) else begin
            errors++;
            $display("FAILED %0t: empty is %b, model holds %0d", $time, empty, model_q.size());
        end
        assert (full === (model_q.size() == PQ_DEPTH)) else begin
            errors++;
            $display("FAILED %0t: full is %b, model holds %0d", $time, full, model_q.size());
        end
        assert (busy === 1'b0 && dp_n === 1'b1) else begin
            errors++;
            $display("FAILED %0t: busy %b dp_n %b, expected 0 and 1", $time, busy, dp_n);
        end
        chk_req = 1'b1;
        t = 0;
        while (chk_req && t < FRAME + TMO) begin
            step();
            t++;
        end
        if (chk_req) begin
            timeouts++;
            $display("Timed out waiting for the display frame check at %0t", $time);
            chk_req = 1'b0;
        end
    endtask

    task automatic run_op(input pq_op_e op, input logic [15:0] word);
        press(op, word, HOLD, 1);
        model_apply(op, word);
        check_all();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        kv_t w;
        logic [7:0] prev_key;
        errors = 0;
        timeouts = 0;
        busy_cnt = 0;
        lfsr = 32'h80c4;
        chk_req = 1'b0;
        frame_cnt = 0;
        seen = '0;
        disp_head = '0;
        rst = 1'b1;
        kvi_logic = '0;
        enq = 1'b0;
        deq = 1'b0;
        repl = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        // Empty queue shows 0000
        check_all();

        // Five random entries
        for (int i = 0; i < 5; i++) begin
            run_op(OP_ENQ, rand_word());
        end
        // Fill with a pair of equal keys, then one rejected enqueue
        w = rand_word();
        run_op(OP_ENQ, w);
        run_op(OP_ENQ, {w.key, ~w.value});
        run_op(OP_ENQ, rand_word());
        run_op(OP_ENQ, rand_word());

        // Drain in key order, then one dequeue too many
        for (int i = 0; i < PQ_DEPTH; i++) begin
            w = model_head();
            prev_key = w.key;
            run_op(OP_DEQ, rand_word());
            assert (model_q.size() == 0 || disp_head.key >= prev_key) else begin
                errors++;
                $display("FAILED %0t: head key %h after %h", $time, disp_head.key, prev_key);
            end
        end
        run_op(OP_DEQ, rand_word());

        // Replace on a partly filled, a full and an empty queue
        for (int i = 0; i < 3; i++) begin
            run_op(OP_ENQ, rand_word());
        end
        run_op(OP_REPL, rand_word());
        for (int i = 0; i < 5; i++) begin
            run_op(OP_ENQ, rand_word());
        end
        run_op(OP_REPL, rand_word());
        for (int i = 0; i < PQ_DEPTH; i++) begin
            run_op(OP_DEQ, rand_word());
        end
        run_op(OP_REPL, rand_word());

        // Short glitches give no command
        press(OP_ENQ, rand_word(), 2, 0);
        press(OP_DEQ, rand_word(), 2, 0);
        check_all();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: hdl/quickq_hw.sv
`timescale 1ns/1ps

module quickq_hw import quickq_pkg::*; #(
    parameter int DB_CYCLES   = DB_CYCLES_DEFAULT,
    parameter int SCAN_CYCLES = SCAN_CYCLES_DEFAULT
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] kvi_logic,
    input  logic        enq,
    input  logic        deq,
    input  logic        repl,
    output logic        full,
    output logic        busy,
    output logic        empty,
    output logic [6:0]  segs_n,
    output logic        dp_n,
    output logic [7:0]  an_n
);

    kv_t kvi;
    kv_t kvo;
    logic enq_p;
    logic deq_p;
    logic repl_p;

    // Switch word as queue entry
    assign kvi = kv_t'(kvi_logic);

    ////////////////////////////////////////////////////////////////////////////
    // Buttons
    ////////////////////////////////////////////////////////////////////////////

    button_pulser #(.DB_CYCLES(DB_CYCLES)) u_enq_btn (.clk, .rst, .pb(enq), .pulse(enq_p));
    button_pulser #(.DB_CYCLES(DB_CYCLES)) u_deq_btn (.clk, .rst, .pb(deq), .pulse(deq_p));
    button_pulser #(.DB_CYCLES(DB_CYCLES)) u_repl_btn (.clk, .rst, .pb(repl), .pulse(repl_p));

    ////////////////////////////////////////////////////////////////////////////
    // Queue core
    ////////////////////////////////////////////////////////////////////////////

    pq_if u_pq_if (.clk);

    quickq u_quickq (u_pq_if.dev);

    // Replace shows up as enq and deq together
    assign u_pq_if.rst = rst;
    assign u_pq_if.kvi = kvi;
    assign u_pq_if.enq = enq_p || repl_p;
    assign u_pq_if.deq = deq_p || repl_p;
    assign kvo   = u_pq_if.kvo;
    assign full  = u_pq_if.full;
    assign busy  = u_pq_if.busy;
    assign empty = u_pq_if.empty;

    ////////////////////////////////////////////////////////////////////////////
    // Display
    ////////////////////////////////////////////////////////////////////////////

    // Key on digits 3..2, value on 1..0, upper four dark
    sevenseg_ctl #(.SCAN_CYCLES(SCAN_CYCLES)) u_sevenseg (
        .clk,
        .rst,
        .d7(SEG_BLANK),
        .d6(SEG_BLANK),
        .d5(SEG_BLANK),
        .d4(SEG_BLANK),
        .d3({3'b000, kvo.key[7:4]}),
        .d2({3'b000, kvo.key[3:0]}),
        .d1({3'b000, kvo.value[7:4]}),
        .d0({3'b000, kvo.value[3:0]}),
        .segs_n,
        .dp_n,
        .an_n
    );

endmodule

// File: hdl/sevenseg_ctl.sv
`timescale 1ns/1ps

module sevenseg_ctl import quickq_pkg::*; #(
    parameter int SCAN_CYCLES = SCAN_CYCLES_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [6:0] d7,
    input  logic [6:0] d6,
    input  logic [6:0] d5,
    input  logic [6:0] d4,
    input  logic [6:0] d3,
    input  logic [6:0] d2,
    input  logic [6:0] d1,
    input  logic [6:0] d0,
    output logic [6:0] segs_n,
    output logic       dp_n,
    output logic [7:0] an_n
);

    localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic [2:0] digit;
    logic [6:0] code;

    // Active-low pattern, bit order g..a
    function automatic logic [6:0] hex_to_seg(input logic [6:0] c);
        case (c)
            7'd0:    return 7'b1000000;
            7'd1:    return 7'b1111001;
            7'd2:    return 7'b0100100;
            7'd3:    return 7'b0110000;
            7'd4:    return 7'b0011001;
            7'd5:    return 7'b0010010;
            7'd6:    return 7'b0000010;
            7'd7:    return 7'b1111000;
            7'd8:    return 7'b0000000;
            7'd9:    return 7'b0010000;
            7'd10:   return 7'b0001000;
            7'd11:   return 7'b0000011;
            7'd12:   return 7'b1000110;
            7'd13:   return 7'b0100001;
            7'd14:   return 7'b0000110;
            7'd15:   return 7'b0001110;
            // Blank code and anything unknown
            default: return 7'b1111111;
        endcase
    endfunction

    // Digit dwell timer and index
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
            scan_cnt <= '0;
            digit    <= digit + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        unique case (digit)
            3'd0: code = d0;
            3'd1: code = d1;
            3'd2: code = d2;
            3'd3: code = d3;
            3'd4: code = d4;
            3'd5: code = d5;
            3'd6: code = d6;
            3'd7: code = d7;
        endcase
    end

    // Segments and anode both follow the index, so they switch together
    assign segs_n = hex_to_seg(code);
    assign an_n   = ~(8'b0000_0001 << digit);
    // Decimal points unused
    assign dp_n   = 1'b1;

endmodule

// File: hdl/button_pulser.sv
`timescale 1ns/1ps

module button_pulser import quickq_pkg::*; #(
    parameter int DB_CYCLES = DB_CYCLES_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    input  logic pb,
    output logic pulse
);

    localparam int CNT_W = $clog2(DB_CYCLES + 1);

    // Two-stage synchronizer, [1] is the safe copy
    logic [1:0] sync_q;
    logic level;
    logic [CNT_W-1:0] stable_cnt;
    logic commit;

    // Level has differed long enough
    assign commit = (stable_cnt == CNT_W'(DB_CYCLES - 1)) && (sync_q[1] != level);

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q     <= '0;
            level      <= 1'b0;
            stable_cnt <= '0;
            pulse      <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], pb};
            // One pulse per committed press
            pulse  <= commit && sync_q[1];
            if (sync_q[1] == level) begin
                // Glitch over, start again
                stable_cnt <= '0;
            end else if (commit) begin
                level      <= sync_q[1];
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // Single-cycle pulse
    a_pulse_single: assert property (@(posedge clk) disable iff (rst)
        pulse |=> !pulse);

endmodule

// File: hdl/quickq.sv
`timescale 1ns/1ps

module quickq import quickq_pkg::*; (
    pq_if.dev pq
);

    pq_state_e state;
    pq_op_e op_q;
    pq_op_e op_dec;
    kv_t kv_q;
    logic [PQ_CNT_W-1:0] count;
    logic [PQ_CNT_W-1:0] count_next;
    logic [PQ_CNT_W-1:0] src_cnt;
    logic do_rem;
    logic do_ins;

    // Sorted storage, head at index 0
    kv_t q [PQ_DEPTH];
    // Array after the optional head removal
    kv_t src [PQ_DEPTH];
    kv_t q_next [PQ_DEPTH];
    // Valid entries whose key beats the new key
    logic [PQ_DEPTH-1:0] gt;

    ////////////////////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////////////////////

    assign pq.busy  = (state == ST_COMMIT);
    assign pq.full  = (count == PQ_CNT_W'(PQ_DEPTH));
    assign pq.empty = (count == '0);
    // Zero head while nothing is stored
    assign pq.kvo   = pq.empty ? '0 : q[0];

    // Command decode against current occupancy
    always_comb begin
        op_dec = OP_NONE;
        if (pq.enq && pq.deq) begin
            // Replace on empty degrades to enqueue
            op_dec = pq.empty ? OP_ENQ : OP_REPL;
        end else if (pq.enq) begin
            op_dec = pq.full ? OP_NONE : OP_ENQ;
        end else if (pq.deq) begin
            op_dec = pq.empty ? OP_NONE : OP_DEQ;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shift and insert
    ////////////////////////////////////////////////////////////////////////////

    assign do_rem  = (op_q == OP_DEQ) || (op_q == OP_REPL);
    assign do_ins  = (op_q == OP_ENQ) || (op_q == OP_REPL);
    assign src_cnt = do_rem ? count - 1'b1 : count;

    always_comb begin
        // Pop the head first
        src = q;
        if (do_rem) begin
            for (int i = 0; i < PQ_DEPTH - 1; i++) begin
                src[i] = q[i + 1];
            end
        end
        // Strictly greater only, so equal keys keep arrival order
        for (int i = 0; i < PQ_DEPTH; i++) begin
            gt[i] = (PQ_CNT_W'(i) < src_cnt) && (src[i].key > kv_q.key);
        end
        // Larger keys slide back one, new entry fills the gap
        q_next[0] = (gt[0] || src_cnt == '0) ? kv_q : src[0];
        for (int i = 1; i < PQ_DEPTH; i++) begin
            if (gt[i - 1]) begin
                q_next[i] = src[i - 1];
            end else if (gt[i] || src_cnt == PQ_CNT_W'(i)) begin
                q_next[i] = kv_q;
            end else begin
                q_next[i] = src[i];
            end
        end
        if (!do_ins) begin
            q_next = src;
        end
    end

    always_comb begin
        unique case (op_q)
            OP_ENQ:  count_next = count + 1'b1;
            OP_DEQ:  count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    // Control state
    always_ff @(posedge pq.clk) begin
        if (pq.rst) begin
            state <= ST_IDLE;
            op_q  <= OP_NONE;
            count <= '0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (pq.enq || pq.deq) begin
                        state <= ST_COMMIT;
                        op_q  <= op_dec;
                    end
                end
                ST_COMMIT: begin
                    state <= ST_IDLE;
                    count <= count_next;
                end
            endcase
        end
    end

    // Payload
    always_ff @(posedge pq.clk) begin
        if (state == ST_IDLE && (pq.enq || pq.deq)) begin
            kv_q <= pq.kvi;
        end
        if (state == ST_COMMIT) begin
            q <= q_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_count_max: assert property (@(posedge pq.clk) disable iff (pq.rst)
        count <= PQ_CNT_W'(PQ_DEPTH));

    // Accepted pulse gives exactly one busy cycle
    a_busy_one: assert property (@(posedge pq.clk) disable iff (pq.rst)
        (!pq.busy && (pq.enq || pq.deq)) |=> pq.busy ##1 !pq.busy);

    for (genvar i = 0; i < PQ_DEPTH - 1; i++) begin : g_sorted
        a_sorted: assert property (@(posedge pq.clk) disable iff (pq.rst)
            (PQ_CNT_W'(i + 1) < count) |-> (q[i].key <= q[i + 1].key));
    end

endmodule

// File: hdl/pq_if.sv
`timescale 1ns/1ps

interface pq_if import quickq_pkg::*; (
    input logic clk
);

    // Top to core
    logic rst;
    kv_t  kvi;
    // Both together request a replace
    logic enq;
    logic deq;

    // Core to top
    kv_t  kvo;
    logic full;
    logic empty;
    // High for the one commit cycle of a command
    logic busy;

    // Core side
    modport dev (
        input  clk,
        input  rst,
        input  kvi,
        input  enq,
        input  deq,
        output kvo,
        output full,
        output empty,
        output busy
    );

endinterface

// File: hdl/quickq_pkg.sv
package quickq_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Queue entry
    ////////////////////////////////////////////////////////////////////////////

    // Smaller key leaves the queue first
    typedef struct packed {
        logic [7:0] key;
        logic [7:0] value;
    } kv_t;

    // Operation latched by the core in the accept cycle
    typedef enum logic [1:0] {
        OP_NONE,
        OP_ENQ,
        OP_DEQ,
        OP_REPL
    } pq_op_e;

    // Core control state
    typedef enum logic {
        ST_IDLE,
        ST_COMMIT
    } pq_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Sizing
    ////////////////////////////////////////////////////////////////////////////

    localparam int PQ_DEPTH = 8;
    // Must hold 0..PQ_DEPTH
    localparam int PQ_CNT_W = 4;

    // About 650 us of stable level at 100 MHz
    localparam int DB_CYCLES_DEFAULT = 65536;
    // Time each display digit stays lit
    localparam int SCAN_CYCLES_DEFAULT = 16384;

    // Digit code that turns all segments off
    localparam logic [6:0] SEG_BLANK = 7'h7f;

endpackage
